//--- compile.f
hdl/cam_pkg.sv
hdl/ov7670_capture.sv
hdl/frame_buffer.sv
hdl/vga_scan.sv
hdl/target_finder.sv
hdl/classification.sv
hdl/cam_vision_top.sv
tb/cam_vision_asserts.sv
tb/cam_vision_tb.sv

//--- Bender.yml
package:
  name: cam_vision

sources:
  - files:
      - hdl/cam_pkg.sv
      - hdl/ov7670_capture.sv
      - hdl/frame_buffer.sv
      - hdl/vga_scan.sv
      - hdl/target_finder.sv
      - hdl/classification.sv
      - hdl/cam_vision_top.sv
  - target: simulation
    files:
      - tb/cam_vision_asserts.sv
      - tb/cam_vision_tb.sv

//--- tb/cam_vision_tb.sv
// Testbench with clock, reset, frame table, camera driver and displayed frame checker
`default_nettype none
`timescale 1ns/10ps

module cam_vision_tb;

  import cam_pkg::*;

  // Longest wait for any display event
  localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;
  localparam vga_out_t VGA_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0,
                                    r: '0, g: '0, b: '0};

  // One stimulus entry with its expected decision
  typedef struct packed {
    rgb444_t    bg;
    rgb444_t    fg;
    col_t       x0;
    col_t       x1;
    row_t       y0;
    row_t       y1;
    logic [8:0] noise;
    row_t       abort_rows;
    logic       mid_reset;
    dir_t       exp_dir;
    logic       exp_det;
  } frame_entry_t;

  logic      clk = 1'b0;
  logic      rst_n;
  cam_bus_t  cam;
  vga_out_t  vga;
  dir_t      direction;
  logic      orange_detected;
  int        seed;
  rgb444_t   ref_img [PIX_COUNT];

  // bg, fg, x0, x1, y0, y1, noise, abort rows, mid reset, direction, detected
  // Empty rectangle when x0 > x1
  frame_entry_t frames [10] = '{
    '{12'h234, 12'h000,  1,  0,  0,  0, 300,  0, 0, DIR_NONE,   1'b0},
    '{12'h135, 12'hA40,  2,  9,  5,  9,   0,  0, 0, DIR_LEFT,   1'b1},
    '{12'h258, 12'hF94, 25, 35, 10, 12,   0,  0, 1, DIR_CENTER, 1'b1},
    '{12'h0F0, 12'hC62, 50, 60, 30, 40,   0, 20, 0, DIR_RIGHT,  1'b1},
    '{12'h111, 12'hB53, 17, 24,  0,  1,   0,  0, 0, DIR_CENTER, 1'b1},
    '{12'h111, 12'hB53, 38, 45, 47, 47,   0,  0, 0, DIR_CENTER, 1'b1},
    '{12'h321, 12'hD72, 30, 36, 20, 20,   0,  0, 0, DIR_NONE,   1'b0},
    '{12'h321, 12'hD72, 56, 63, 47, 47,   0,  0, 0, DIR_RIGHT,  1'b1},
    '{12'h940, 12'hA30,  0, 31,  0, 23,   0,  0, 0, DIR_NONE,   1'b0},
    '{12'hAA0, 12'hA45, 32, 63, 24, 47,   0,  0, 0, DIR_NONE,   1'b0}
  };

  cam_vision_top i_dut (
    .clk(clk), .rst_n(rst_n), .cam(cam),
    .vga(vga), .direction(direction), .orange_detected(orange_detected)
  );

  always #4 clk = ~clk;

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_failed();
  endtask

  task automatic fail_text(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  // Bound property failures end the run at once
  always @(negedge clk) begin
    if (i_dut.i_asserts.fail_count != 0) begin
      fail_text("A bound assertion on the DUT outputs failed");
    end
  end

  // Inclusive orange window on 4-bit channels
  function automatic logic in_orange_window(input rgb444_t p);
    return (p[11:8] >= ORANGE_R_MIN) && (p[7:4] >= ORANGE_G_MIN) &&
           (p[7:4] <= ORANGE_G_MAX) && (p[3:0] <= ORANGE_B_MAX);
  endfunction

  // Displayed 8-bit channels for one stored pixel
  function automatic logic [23:0] shown_rgb(input rgb444_t p);
    if (in_orange_window(p)) begin
      return {HIGHLIGHT_R, HIGHLIGHT_G, HIGHLIGHT_B};
    end
    return {p[11:8], p[11:8], p[7:4], p[7:4], p[3:0], p[3:0]};
  endfunction

  task automatic build_image(input frame_entry_t e);
    int x;
    int y;
    int idx;
    rgb444_t n;
    for (y = 0; y < V_ACTIVE; y++) begin
      for (x = 0; x < H_ACTIVE; x++) begin
        ref_img[y * H_ACTIVE + x] = (x >= e.x0 && x <= e.x1 && y >= e.y0 && y <= e.y1) ?
                                    e.fg : e.bg;
      end
    end
    // Noise pixels pushed out of the window through blue
    repeat (e.noise) begin
      idx = {$random(seed)} % PIX_COUNT;
      n   = rgb444_t'($random(seed));
      if (in_orange_window(n)) begin
        n[3:0] = 4'hf;
      end
      ref_img[idx] = n;
    end
  endtask

  task automatic drive_cam(input logic vs, input logic hr, input logic en, input logic [7:0] d);
    @(negedge clk);
    cam = '{vsync: vs, href: hr, pclk_en: en, data: d};
  endtask

  // Camera frame with inverted data for an aborted one
  task automatic send_frame(input int rows, input logic invert);
    int r;
    int c;
    rgb444_t p;
    repeat (3) drive_cam(1'b1, 1'b0, 1'b0, 8'($random(seed)));
    repeat (4) drive_cam(1'b0, 1'b0, 1'b0, 8'($random(seed)));
    for (r = 0; r < rows; r++) begin
      for (c = 0; c < H_ACTIVE; c++) begin
        p = ref_img[r * H_ACTIVE + c] ^ {12{invert}};
        // Upper nibble of the red byte is junk
        drive_cam(1'b0, 1'b1, 1'b1, {4'($random(seed)), p[11:8]});
        drive_cam(1'b0, 1'b1, 1'b1, p[7:0]);
        drive_cam(1'b0, 1'b1, 1'b0, 8'($random(seed)));
      end
      // Strobes outside href are ignored
      repeat (4) drive_cam(1'b0, 1'b0, 1'b1, 8'($random(seed)));
    end
    drive_cam(1'b0, 1'b0, 1'b0, 8'h00);
  endtask

  task automatic wait_level(input logic on_blank, input logic lvl, input string what);
    int cycles;
    logic cur;
    cycles = 0;
    cur    = on_blank ? vga.blank_n : vga.vsync_n;
    while (cur !== lvl) begin
      if (cycles >= FRAME_CYCLES) begin
        fail_text({"Timeout while waiting for ", what});
      end
      @(negedge clk);
      cycles++;
      cur = on_blank ? vga.blank_n : vga.vsync_n;
    end
  endtask

  task automatic reset_mid_frame();
    wait_level(1'b1, 1'b1, "a visible pixel before the reset");
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    assert (vga == VGA_IDLE) else fail_value("vga", vga, VGA_IDLE);
    assert (direction == DIR_NONE) else fail_value("direction", direction, DIR_NONE);
    assert (orange_detected == 1'b0) else fail_value("orange_detected", orange_detected, 0);
    rst_n = 1'b1;
  endtask

  // One displayed frame from just after vsync up to the next vsync
  task automatic check_frame();
    int pix;
    int run;
    int lines;
    int cycles;
    logic [23:0] exp;
    pix    = 0;
    run    = 0;
    lines  = 0;
    cycles = 0;
    while (vga.vsync_n) begin
      if (vga.blank_n) begin
        exp = shown_rgb(ref_img[pix]);
        assert ({vga.r, vga.g, vga.b} == exp)
          else fail_value($sformatf("vga rgb at pixel %0d", pix), {vga.r, vga.g, vga.b}, exp);
        pix++;
        run++;
      end else begin
        assert ({vga.r, vga.g, vga.b} == 24'h0)
          else fail_value("vga rgb while blanked", {vga.r, vga.g, vga.b}, 0);
        if (run != 0) begin
          assert (run == H_ACTIVE) else fail_value("active pixels per line", run, H_ACTIVE);
          lines++;
          run = 0;
        end
      end
      if (cycles >= FRAME_CYCLES) begin
        fail_text("Timeout while waiting for vsync at the end of the checked frame");
      end
      @(negedge clk);
      cycles++;
    end
    assert (lines == V_ACTIVE) else fail_value("active lines per frame", lines, V_ACTIVE);
  endtask

  initial begin
    rst_n = 1'b0;
    cam   = '0;
    seed  = 32'hef96;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    foreach (frames[i]) begin
      build_image(frames[i]);
      // Aborted capture restarted by the next vsync
      if (frames[i].abort_rows != 0) begin
        send_frame(frames[i].abort_rows, 1'b1);
      end
      send_frame(V_ACTIVE, 1'b0);
      if (frames[i].mid_reset) begin
        reset_mid_frame();
      end
      // Skip to the start of a frame read entirely from the new image
      wait_level(1'b0, 1'b0, "vsync_n low");
      wait_level(1'b0, 1'b1, "vsync_n high");
      check_frame();
      assert (direction == frames[i].exp_dir)
        else fail_value("direction", direction, frames[i].exp_dir);
      assert (orange_detected == frames[i].exp_det)
        else fail_value("orange_detected", orange_detected, frames[i].exp_det);
    end
    if (i_dut.i_asserts.fail_count != 0) begin
      fail_text("A bound assertion on the DUT outputs failed");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb/cam_vision_asserts.sv
// Bound concurrent checks on VGA blanking, hsync width and classifier output stability
`default_nettype none
`timescale 1ns/10ps

module cam_vision_asserts (
  input  wire                 clk,
  input  wire                 rst_n,
  input  cam_pkg::vga_out_t   vga,
  input  cam_pkg::raster_t    fin_raster,
  input  cam_pkg::dir_t       direction,
  input  wire                 orange_detected
);

  import cam_pkg::*;

  // Number of failed properties so far
  int unsigned fail_count = 0;

  // Black outside the visible area
  blank_black: assert property (@(posedge clk) disable iff (!rst_n)
    !vga.blank_n |-> (vga.r == '0) && (vga.g == '0) && (vga.b == '0))
    else begin
      fail_count++;
      $error("RGB channels not zero while blank_n is low");
    end

  // Decision moves only in the cycle after the last visible pixel
  decision_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(fin_raster.frame_end) |->
      (direction === $past(direction)) && (orange_detected === $past(orange_detected)))
    else begin
      fail_count++;
      $error("direction or orange_detected changed away from a frame end");
    end

  // Line sync low for exactly H_SYNC clocks
  hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(vga.hsync_n) |-> (!vga.hsync_n) [*H_SYNC] ##1 vga.hsync_n)
    else begin
      fail_count++;
      $error("hsync_n low pulse has the wrong length");
    end

endmodule

bind cam_vision_top cam_vision_asserts i_asserts (
  .clk(clk), .rst_n(rst_n), .vga(vga), .fin_raster(fin_raster),
  .direction(direction), .orange_detected(orange_detected)
);

`default_nettype wire

//--- hdl/cam_vision_top.sv
// Vision path top level joining capture, frame buffer, scan, target finder and classifier
`default_nettype none
`timescale 1ns/10ps

module cam_vision_top (
  input  wire                clk,
  input  wire                rst_n,
  input  cam_pkg::cam_bus_t  cam,
  output cam_pkg::vga_out_t  vga,
  output cam_pkg::dir_t      direction,
  output logic               orange_detected
);

  import cam_pkg::*;

  // Capture to buffer write port
  logic      wr_en;
  pix_addr_t wr_addr;
  rgb444_t   wr_pix;
  // Scan to buffer read port
  pix_addr_t rd_addr;
  raster_t   scan;
  // Buffer to finder, one cycle later
  rgb444_t   rd_pix;
  raster_t   buf_raster;
  // Finder to classifier
  raster_t   fin_raster;
  logic      is_orange;

  ov7670_capture i_capture (
    .clk(clk), .rst_n(rst_n), .cam(cam),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_pix(wr_pix)
  );

  frame_buffer i_frame_buffer (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_pix(wr_pix),
    .rd_addr(rd_addr), .scan(scan), .rd_pix(rd_pix), .buf_raster(buf_raster)
  );

  vga_scan i_vga_scan (.clk(clk), .rst_n(rst_n), .scan(scan), .rd_addr(rd_addr));

  target_finder i_target_finder (
    .clk(clk), .rst_n(rst_n), .rd_pix(rd_pix), .buf_raster(buf_raster),
    .vga(vga), .fin_raster(fin_raster), .is_orange(is_orange)
  );

  classification i_classification (
    .clk(clk), .rst_n(rst_n), .fin_raster(fin_raster), .is_orange(is_orange),
    .direction(direction), .orange_detected(orange_detected)
  );

endmodule

`default_nettype wire

//--- hdl/classification.sv
// Per-third orange pixel counters and frame-end steering direction and detection flag
`default_nettype none
`timescale 1ns/10ps

module classification (
  input  wire                 clk,
  input  wire                 rst_n,
  input  cam_pkg::raster_t    fin_raster,
  input  wire                 is_orange,
  output cam_pkg::dir_t       direction,
  output logic                orange_detected
);

  import cam_pkg::*;

  // Running counts for the current frame
  pix_count_t left_cnt;
  pix_count_t center_cnt;
  pix_count_t right_cnt;
  // Counts including the current pixel
  pix_count_t left_nxt;
  pix_count_t center_nxt;
  pix_count_t right_nxt;
  pix_count_t total;
  logic       in_left;
  logic       in_center;
  logic       detected;
  dir_t       dir_pick;

  // Column thirds, the right one takes the remainder
  assign in_left   = fin_raster.col < col_t'(THIRD_W);
  assign in_center = !in_left && (fin_raster.col < col_t'(2 * THIRD_W));

  always_comb begin
    left_nxt   = left_cnt + pix_count_t'(is_orange && in_left);
    center_nxt = center_cnt + pix_count_t'(is_orange && in_center);
    right_nxt  = right_cnt + pix_count_t'(is_orange && !in_left && !in_center);
    total      = left_nxt + center_nxt + right_nxt;
    detected   = total >= pix_count_t'(DETECT_MIN);
  end

  // Largest third wins
  // ties prefer center, then left
  always_comb begin
    if (!detected) begin
      dir_pick = DIR_NONE;
    end else if ((center_nxt >= left_nxt) && (center_nxt >= right_nxt)) begin
      dir_pick = DIR_CENTER;
    end else if (left_nxt >= right_nxt) begin
      dir_pick = DIR_LEFT;
    end else begin
      dir_pick = DIR_RIGHT;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      left_cnt        <= '0;
      center_cnt      <= '0;
      right_cnt       <= '0;
      direction       <= DIR_NONE;
      orange_detected <= 1'b0;
    end else if (fin_raster.frame_end) begin
      // Decision once per frame, then start counting afresh
      direction       <= dir_pick;
      orange_detected <= detected;
      left_cnt        <= '0;
      center_cnt      <= '0;
      right_cnt       <= '0;
    end else begin
      left_cnt   <= left_nxt;
      center_cnt <= center_nxt;
      right_cnt  <= right_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hdl/target_finder.sv
// Orange color window test, highlight and RGB444 to 8-bit VGA output stage
`default_nettype none
`timescale 1ns/10ps

module target_finder (
  input  wire                 clk,
  input  wire                 rst_n,
  input  cam_pkg::rgb444_t    rd_pix,
  input  cam_pkg::raster_t    buf_raster,
  output cam_pkg::vga_out_t   vga,
  output cam_pkg::raster_t    fin_raster,
  output logic                is_orange
);

  import cam_pkg::*;

  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;
  logic       in_window;
  logic       orange;

  // Split the stored word into channels
  assign red   = rd_pix[11:8];
  assign green = rd_pix[7:4];
  assign blue  = rd_pix[3:0];

  // Window bounds are inclusive
  assign in_window = (red >= 4'(ORANGE_R_MIN)) &&
                     (green >= 4'(ORANGE_G_MIN)) && (green <= 4'(ORANGE_G_MAX)) &&
                     (blue <= 4'(ORANGE_B_MAX));
  assign orange    = buf_raster.active && in_window;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Idle raster: syncs released, blanked, black
      vga        <= '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0, r: '0, g: '0, b: '0};
      fin_raster <= '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0, col: '0, frame_end: 1'b0};
      is_orange  <= 1'b0;
    end else begin
      vga.hsync_n <= buf_raster.hsync_n;
      vga.vsync_n <= buf_raster.vsync_n;
      vga.blank_n <= buf_raster.active;
      if (!buf_raster.active) begin
        // Channels forced to black outside the visible area
        vga.r <= '0;
        vga.g <= '0;
        vga.b <= '0;
      end else if (orange) begin
        vga.r <= HIGHLIGHT_R;
        vga.g <= HIGHLIGHT_G;
        vga.b <= HIGHLIGHT_B;
      end else begin
        // Nibble replication spans the full 8-bit range
        vga.r <= {red, red};
        vga.g <= {green, green};
        vga.b <= {blue, blue};
      end
      fin_raster <= buf_raster;
      is_orange  <= orange;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_scan.sv
// VGA raster timing with sync and active generation and linear read address
`default_nettype none
`timescale 1ns/10ps

module vga_scan (
  input  wire                 clk,
  input  wire                 rst_n,
  output cam_pkg::raster_t    scan,
  output cam_pkg::pix_addr_t  rd_addr
);

  import cam_pkg::*;

  // Position counters over the whole raster including porches
  col_t h_cnt;
  row_t v_cnt;
  logic h_last;
  logic v_last;
  logic h_active;
  logic v_active;
  logic h_sync_on;
  logic v_sync_on;
  logic active;
  logic frame_end;

  // End of line and end of frame
  assign h_last = h_cnt == col_t'(H_TOTAL - 1);
  assign v_last = v_cnt == row_t'(V_TOTAL - 1);

  // Visible area starts at column 0, row 0
  assign h_active = h_cnt < col_t'(H_ACTIVE);
  assign v_active = v_cnt < row_t'(V_ACTIVE);
  assign active   = h_active && v_active;

  // Sync intervals follow the front porch
  assign h_sync_on = (h_cnt >= col_t'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt < col_t'(H_ACTIVE + H_FRONT + H_SYNC));
  assign v_sync_on = (v_cnt >= row_t'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt < row_t'(V_ACTIVE + V_FRONT + V_SYNC));

  // Last visible pixel of the frame
  assign frame_end = (h_cnt == col_t'(H_ACTIVE - 1)) && (v_cnt == row_t'(V_ACTIVE - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt   <= '0;
      v_cnt   <= '0;
      rd_addr <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        // Row wraps after the vertical back porch
        if (v_last) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      // Read address walks the active pixels only
      if (frame_end) begin
        rd_addr <= '0;
      end else if (active) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // Raster info, sync active low
  always_comb begin
    scan.hsync_n   = !h_sync_on;
    scan.vsync_n   = !v_sync_on;
    scan.active    = active;
    scan.col       = h_cnt;
    scan.frame_end = frame_end;
  end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
// One-frame dual-port pixel memory with registered read and aligned raster info
`default_nettype none
`timescale 1ns/10ps

module frame_buffer (
  input  wire                 clk,
  input  wire                 wr_en,
  input  cam_pkg::pix_addr_t  wr_addr,
  input  cam_pkg::rgb444_t    wr_pix,
  input  cam_pkg::pix_addr_t  rd_addr,
  input  cam_pkg::raster_t    scan,
  output cam_pkg::rgb444_t    rd_pix,
  output cam_pkg::raster_t    buf_raster
);

  import cam_pkg::*;

  // One word per active pixel, raster order
  rgb444_t mem [PIX_COUNT];

  // Write port, fed by capture
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pix;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    rd_pix <= mem[rd_addr];
  end

  // Raster delayed by the same cycle
  // so pixel data and position leave together
  always_ff @(posedge clk) begin
    buf_raster <= scan;
  end

endmodule

`default_nettype wire

//--- hdl/ov7670_capture.sv
// Camera byte-pair capture into RGB444 pixels with frame buffer write strobe and address
`default_nettype none
`timescale 1ns/10ps

module ov7670_capture (
  input  wire                 clk,
  input  wire                 rst_n,
  input  cam_pkg::cam_bus_t   cam,
  output logic                wr_en,
  output cam_pkg::pix_addr_t  wr_addr,
  output cam_pkg::rgb444_t    wr_pix
);

  import cam_pkg::*;

  // High while waiting for the green/blue byte of a pair
  logic      second_byte;
  // Red nibble held from the first byte
  logic [3:0] red_nib;
  // Linear address of the next pixel to store
  pix_addr_t addr;
  logic      byte_valid;
  logic      addr_in_range;

  // A byte counts only inside href
  assign byte_valid    = cam.href && cam.pclk_en;
  assign addr_in_range = addr < pix_addr_t'(PIX_COUNT);

  // Control state: byte phase, address counter, write strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      second_byte <= 1'b0;
      addr        <= '0;
      wr_en       <= 1'b0;
    end else begin
      // Strobe is one cycle wide by default
      wr_en <= 1'b0;
      if (cam.vsync) begin
        // New frame restarts the byte pairing and the write address
        second_byte <= 1'b0;
        addr        <= '0;
      end else if (byte_valid) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          // Writes past the end of the buffer are dropped
          wr_en <= addr_in_range;
          if (addr_in_range) begin
            addr <= addr + 1'b1;
          end
        end
      end
    end
  end

  // Payload path: red nibble and assembled pixel
  always_ff @(posedge clk) begin
    if (byte_valid && !cam.vsync) begin
      if (!second_byte) begin
        // First byte carries red in its low nibble
        red_nib <= cam.data[3:0];
      end else begin
        // Second byte is green high, blue low
        wr_pix  <= {red_nib, cam.data};
        wr_addr <= addr;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cam_pkg.sv
// Raster, color and detection constants, vector types, direction enum and bus structs
`default_nettype none

package cam_pkg;

  // Vector types with a meaning of their own
  typedef logic [11:0] pix_addr_t;
  typedef logic [6:0]  col_t;
  typedef logic [5:0]  row_t;
  // Red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] rgb444_t;
  typedef logic [7:0]  chan8_t;
  typedef logic [12:0] pix_count_t;

  // Scaled-down raster with horizontal values in pixels and vertical ones in lines
  localparam int H_ACTIVE  = 64;
  localparam int H_FRONT   = 4;
  localparam int H_SYNC    = 8;
  localparam int H_BACK    = 4;
  localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACTIVE  = 48;
  localparam int V_FRONT   = 2;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 2;
  localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int PIX_COUNT = H_ACTIVE * V_ACTIVE;

  // Orange window on 4-bit channels with inclusive bounds
  localparam int ORANGE_R_MIN = 10;
  localparam int ORANGE_G_MIN = 4;
  localparam int ORANGE_G_MAX = 9;
  localparam int ORANGE_B_MAX = 4;

  // Highlight color for orange pixels
  localparam chan8_t HIGHLIGHT_R = 8'hff;
  localparam chan8_t HIGHLIGHT_G = 8'h00;
  localparam chan8_t HIGHLIGHT_B = 8'h00;

  // Minimum orange pixels per frame and width of one column third
  localparam int DETECT_MIN = 8;
  localparam int THIRD_W    = H_ACTIVE / 3;

  typedef enum logic [1:0] {DIR_NONE, DIR_LEFT, DIR_CENTER, DIR_RIGHT} dir_t;

  typedef struct packed {
    logic       vsync;
    logic       href;
    logic       pclk_en;
    logic [7:0] data;
  } cam_bus_t;

  typedef struct packed {
    logic hsync_n;
    logic vsync_n;
    logic active;
    col_t col;
    logic frame_end;
  } raster_t;

  typedef struct packed {
    logic   hsync_n;
    logic   vsync_n;
    logic   blank_n;
    chan8_t r;
    chan8_t g;
    chan8_t b;
  } vga_out_t;

endpackage

`default_nettype wire
